/* board_dip.sv */
module board_dip (
    input  logic        clk,
    input  logic        rst,
    input  logic        game_pause,
    input  logic [63:0] status,
    output logic        dip_flip,
    output logic        dip_test,
    output logic        dip_pause,
    output logic        autofire_en,
    output logic        enable_fm,
    output logic        enable_psg,
    output logic [1:0]  rotate
);

    always_ff @(posedge clk) begin
        if (rst) begin
            dip_flip    <= 1'b0;
            dip_test    <= 1'b0;
            dip_pause   <= 1'b0;
            autofire_en <= 1'b0;
            enable_fm   <= 1'b0;
            enable_psg  <= 1'b0;
            rotate      <= 2'd0;
        end else begin
            dip_flip    <= status[ctrl_pkg::ST_FLIP];
            dip_test    <= status[ctrl_pkg::ST_TEST];
            // OSD pause or the joystick pause toggle
            dip_pause   <= status[ctrl_pkg::ST_PAUSE] | game_pause;
            autofire_en <= status[ctrl_pkg::ST_AUTOFIRE];
            // Status holds disable bits, so sound chips default to on
            enable_fm   <= ~status[ctrl_pkg::ST_FM_OFF];
            enable_psg  <= ~status[ctrl_pkg::ST_PSG_OFF];
            rotate      <= status[ctrl_pkg::ST_ROTATE +: 2];
        end
    end

endmodule

/* board_inputs.sv */
module board_inputs #(
    parameter int BUTTONS         = 2,
    parameter bit GAME_ACTIVE_LOW = 1'b1
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          game_rst,
    input  logic                          vs,
    input  logic                          autofire_en,
    input  logic [ctrl_pkg::JOY_IN_W-1:0]  board_joystick1,
    input  logic [ctrl_pkg::JOY_IN_W-1:0]  board_joystick2,
    input  logic [ctrl_pkg::JOY_IN_W-1:0]  board_joystick3,
    input  logic [ctrl_pkg::JOY_IN_W-1:0]  board_joystick4,
    input  logic [3:0]                    board_coin,
    input  logic [3:0]                    board_start,
    output logic [ctrl_pkg::JOY_OUT_W-1:0] game_joystick1,
    output logic [ctrl_pkg::JOY_OUT_W-1:0] game_joystick2,
    output logic [ctrl_pkg::JOY_OUT_W-1:0] game_joystick3,
    output logic [ctrl_pkg::JOY_OUT_W-1:0] game_joystick4,
    output logic [3:0]                    game_coin,
    output logic [3:0]                    game_start,
    output logic                          game_pause,
    output logic                          soft_rst
);

    localparam int JOY_ACTIVE = 4 + BUTTONS;
    localparam logic [ctrl_pkg::JOY_OUT_W-1:0] INV_JOY = {ctrl_pkg::JOY_OUT_W{GAME_ACTIVE_LOW}};
    localparam logic [3:0] INV_4 = {4{GAME_ACTIVE_LOW}};

    logic vs_q;
    logic frame;
    logic pause_q;
    logic combo_q;
    logic fire_off;
    logic combo;

    // Board side is active high, game side follows GAME_ACTIVE_LOW
    function automatic logic [ctrl_pkg::JOY_OUT_W-1:0] map_joy(
        input logic [ctrl_pkg::JOY_IN_W-1:0] joy,
        input logic                         drop_btn0
    );
        logic [ctrl_pkg::JOY_OUT_W-1:0] res;
        res = joy[ctrl_pkg::JOY_OUT_W-1:0];
        for (int i = 0; i < ctrl_pkg::JOY_OUT_W; i++) begin
            if (i >= JOY_ACTIVE) begin
                res[i] = 1'b0;
            end
        end
        if (drop_btn0) begin
            res[ctrl_pkg::JOY_BTN0] = 1'b0;
        end
        return res ^ INV_JOY;
    endfunction

    // Odd frames release button 0 while autofire is on
    assign fire_off = autofire_en & frame;
    assign combo    = board_start[0] & board_coin[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            game_joystick1 <= INV_JOY;
            game_joystick2 <= INV_JOY;
            game_joystick3 <= INV_JOY;
            game_joystick4 <= INV_JOY;
            game_coin      <= INV_4;
            game_start     <= INV_4;
        end else begin
            game_joystick1 <= map_joy(board_joystick1, fire_off);
            game_joystick2 <= map_joy(board_joystick2, fire_off);
            game_joystick3 <= map_joy(board_joystick3, fire_off);
            game_joystick4 <= map_joy(board_joystick4, fire_off);
            game_coin      <= board_coin ^ INV_4;
            game_start     <= board_start ^ INV_4;
        end
    end

    // Frame parity from vs rising edges
    always_ff @(posedge clk) begin
        if (rst) begin
            vs_q  <= 1'b0;
            frame <= 1'b0;
        end else begin
            vs_q <= vs;
            if (vs && !vs_q) begin
                frame <= ~frame;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (game_rst) begin
            game_pause <= 1'b0;
        end else if (board_joystick1[ctrl_pkg::JOY_PAUSE] && !pause_q) begin
            game_pause <= ~game_pause;
        end
    end

    // Start 0 plus coin 0 requests a game reset
    always_ff @(posedge clk) begin
        if (rst) begin
            pause_q  <= 1'b0;
            combo_q  <= 1'b0;
            soft_rst <= 1'b0;
        end else begin
            pause_q  <= board_joystick1[ctrl_pkg::JOY_PAUSE];
            combo_q  <= combo;
            soft_rst <= combo & ~combo_q;
        end
    end

    a_soft_rst_pulse: assert property (@(posedge clk) soft_rst |=> !soft_rst);

endmodule

/* board_led.sv */
module board_led #(
    parameter int BLINK_FRAMES = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       lvbl,
    input  logic       downloading,
    input  logic       osd_shown,
    input  logic [1:0] game_led,
    output logic       led
);

    localparam int FW = (BLINK_FRAMES > 1) ? $clog2(BLINK_FRAMES) : 1;

    ctrl_pkg::led_mode_t mode;
    logic                lvbl_q;
    logic [FW-1:0]       frame_cnt;
    logic                blink;
    logic                lvbl_fall;

    // Download wins over the OSD
    always_comb begin
        if (downloading) begin
            mode = ctrl_pkg::LED_BLINK;
        end else if (osd_shown) begin
            mode = ctrl_pkg::LED_OSD;
        end else begin
            mode = ctrl_pkg::LED_GAME;
        end
    end

    assign lvbl_fall = lvbl_q & ~lvbl;

    always_ff @(posedge clk) begin
        lvbl_q <= lvbl;
        if (rst) begin
            frame_cnt <= '0;
            blink     <= 1'b0;
            led       <= 1'b0;
        end else begin
            if (mode != ctrl_pkg::LED_BLINK) begin
                frame_cnt <= '0;
                blink     <= 1'b0;
            end else if (lvbl_fall) begin
                if (frame_cnt == FW'(BLINK_FRAMES - 1)) begin
                    frame_cnt <= '0;
                    blink     <= ~blink;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
            case (mode)
                ctrl_pkg::LED_BLINK: led <= blink;
                ctrl_pkg::LED_OSD:   led <= 1'b1;
                default:             led <= game_led[0];
            endcase
        end
    end

    // LED holds between lvbl falling edges while downloading
    a_led_blink_hold: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) && $past(downloading) && $past(downloading, 2) && !$past(lvbl_fall, 2)
        |-> $stable(led));

endmodule

/* board_reset.sv */
module board_reset #(
    parameter int RESET_HOLD = 16
) (
    input  logic clk,
    input  logic reset,
    input  logic pll_locked,
    input  logic downloading,
    input  logic soft_rst,
    output logic rst,
    output logic game_rst
);

    localparam int CW = $clog2(RESET_HOLD + 1);

    ctrl_pkg::reset_state_t state;
    logic [CW-1:0]          cnt;
    logic [CW-1:0]          game_cnt;
    logic                   rst_q;
    logic                   dl_q;
    logic                   rst_cause;
    logic                   game_trig;

    assign rst_cause = reset | ~pll_locked;

    // The first cycle with the cause gone already counts as a hold cycle
    always_ff @(posedge clk) begin
        if (rst_cause) begin
            state <= ctrl_pkg::RST_HOLD;
            cnt   <= '0;
        end else begin
            case (state)
                ctrl_pkg::RST_HOLD: begin
                    cnt   <= CW'(1);
                    state <= (RESET_HOLD <= 1) ? ctrl_pkg::RST_RUN : ctrl_pkg::RST_COUNT;
                end
                ctrl_pkg::RST_COUNT: begin
                    if (cnt == CW'(RESET_HOLD - 1)) begin
                        state <= ctrl_pkg::RST_RUN;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ctrl_pkg::RST_RUN: begin
                    cnt <= cnt;
                end
                default: begin
                    state <= ctrl_pkg::RST_HOLD;
                end
            endcase
        end
    end

    assign rst = rst_cause | (state != ctrl_pkg::RST_RUN);

    // Game reset stretch after system reset, download end or soft reset
    assign game_trig = (rst_q & ~rst) | (dl_q & ~downloading) | soft_rst;

    always_ff @(posedge clk) begin
        if (reset) begin
            rst_q    <= 1'b1;
            dl_q     <= 1'b0;
            game_cnt <= '0;
        end else begin
            rst_q <= rst;
            dl_q  <= downloading;
            if (game_trig) begin
                game_cnt <= CW'(RESET_HOLD - 1);
            end else if (game_cnt != '0) begin
                game_cnt <= game_cnt - 1'b1;
            end
        end
    end

    assign game_rst = rst | downloading | game_trig | (game_cnt != '0);

    // Game reset still holds on the last stretch cycle after the system reset
    a_game_hold: assert property (@(posedge clk) $fell(rst) |-> ##(RESET_HOLD - 1) game_rst);

endmodule

/* board_top.f */
ctrl_pkg.sv
video_pkg.sv
board_reset.sv
board_inputs.sv
board_dip.sv
board_led.sv
board_video.sv
board_top.sv
tb_board.sv

/* board_top.sv */
module board_top #(
    parameter int COLORW          = 4,
    parameter bit GAME_ACTIVE_LOW = 1'b1,
    parameter int BUTTONS         = 2,
    parameter int RESET_HOLD      = 16,
    parameter int BLINK_FRAMES    = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          pll_locked,
    input  logic                          downloading,
    output logic                          rst,
    output logic                          game_rst,
    // Player inputs
    input  logic                          vs,
    input  logic [ctrl_pkg::JOY_IN_W-1:0]  board_joystick1,
    input  logic [ctrl_pkg::JOY_IN_W-1:0]  board_joystick2,
    input  logic [ctrl_pkg::JOY_IN_W-1:0]  board_joystick3,
    input  logic [ctrl_pkg::JOY_IN_W-1:0]  board_joystick4,
    input  logic [3:0]                    board_coin,
    input  logic [3:0]                    board_start,
    output logic [ctrl_pkg::JOY_OUT_W-1:0] game_joystick1,
    output logic [ctrl_pkg::JOY_OUT_W-1:0] game_joystick2,
    output logic [ctrl_pkg::JOY_OUT_W-1:0] game_joystick3,
    output logic [ctrl_pkg::JOY_OUT_W-1:0] game_joystick4,
    output logic [3:0]                    game_coin,
    output logic [3:0]                    game_start,
    // OSD settings
    input  logic [63:0]                   status,
    output logic                          dip_pause,
    output logic                          dip_flip,
    output logic                          dip_test,
    output logic                          enable_fm,
    output logic                          enable_psg,
    output logic [1:0]                    rotate,
    // LED
    input  logic                          osd_shown,
    input  logic [1:0]                    game_led,
    output logic                          led,
    // Video
    input  logic                          pxl_cen,
    input  logic                          lhbl,
    input  logic                          lvbl,
    input  logic [COLORW-1:0]             game_r,
    input  logic [COLORW-1:0]             game_g,
    input  logic [COLORW-1:0]             game_b,
    output logic [video_pkg::OUT_W-1:0]    video_r,
    output logic [video_pkg::OUT_W-1:0]    video_g,
    output logic [video_pkg::OUT_W-1:0]    video_b,
    output logic                          video_de
);

    logic soft_rst;
    logic game_pause;
    logic autofire_en;

    board_reset #(.RESET_HOLD(RESET_HOLD)) u_reset (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .pll_locked  ( pll_locked  ),
        .downloading ( downloading ),
        .soft_rst    ( soft_rst    ),
        .rst         ( rst         ),
        .game_rst    ( game_rst    )
    );

    board_inputs #(
        .BUTTONS         ( BUTTONS         ),
        .GAME_ACTIVE_LOW ( GAME_ACTIVE_LOW )
    ) u_inputs (
        .clk             ( clk             ),
        .rst             ( rst             ),
        .game_rst        ( game_rst        ),
        .vs              ( vs              ),
        .autofire_en     ( autofire_en     ),
        .board_joystick1 ( board_joystick1 ),
        .board_joystick2 ( board_joystick2 ),
        .board_joystick3 ( board_joystick3 ),
        .board_joystick4 ( board_joystick4 ),
        .board_coin      ( board_coin      ),
        .board_start     ( board_start     ),
        .game_joystick1  ( game_joystick1  ),
        .game_joystick2  ( game_joystick2  ),
        .game_joystick3  ( game_joystick3  ),
        .game_joystick4  ( game_joystick4  ),
        .game_coin       ( game_coin       ),
        .game_start      ( game_start      ),
        .game_pause      ( game_pause      ),
        .soft_rst        ( soft_rst        )
    );

    board_dip u_dip (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .game_pause  ( game_pause  ),
        .status      ( status      ),
        .dip_flip    ( dip_flip    ),
        .dip_test    ( dip_test    ),
        .dip_pause   ( dip_pause   ),
        .autofire_en ( autofire_en ),
        .enable_fm   ( enable_fm   ),
        .enable_psg  ( enable_psg  ),
        .rotate      ( rotate      )
    );

    board_led #(.BLINK_FRAMES(BLINK_FRAMES)) u_led (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .lvbl        ( lvbl        ),
        .downloading ( downloading ),
        .osd_shown   ( osd_shown   ),
        .game_led    ( game_led    ),
        .led         ( led         )
    );

    board_video #(.COLORW(COLORW)) u_video (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .lhbl     ( lhbl     ),
        .lvbl     ( lvbl     ),
        .game_r   ( game_r   ),
        .game_g   ( game_g   ),
        .game_b   ( game_b   ),
        .video_r  ( video_r  ),
        .video_g  ( video_g  ),
        .video_b  ( video_b  ),
        .video_de ( video_de )
    );

endmodule

/* board_video.sv */
module board_video #(
    parameter int COLORW = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pxl_cen,
    input  logic                      lhbl,
    input  logic                      lvbl,
    input  logic [COLORW-1:0]         game_r,
    input  logic [COLORW-1:0]         game_g,
    input  logic [COLORW-1:0]         game_b,
    output logic [video_pkg::OUT_W-1:0] video_r,
    output logic [video_pkg::OUT_W-1:0] video_g,
    output logic [video_pkg::OUT_W-1:0] video_b,
    output logic                      video_de
);

    logic [video_pkg::OUT_W-1:0] r_wide;
    logic [video_pkg::OUT_W-1:0] g_wide;
    logic [video_pkg::OUT_W-1:0] b_wide;
    logic                        active;

    // Game colour placed in the low bits before extension
    always_comb begin
        r_wide             = '0;
        g_wide             = '0;
        b_wide             = '0;
        r_wide[COLORW-1:0] = game_r;
        g_wide[COLORW-1:0] = game_g;
        b_wide[COLORW-1:0] = game_b;
    end

    assign active = lhbl & lvbl;

    always_ff @(posedge clk) begin
        if (rst) begin
            video_r  <= '0;
            video_g  <= '0;
            video_b  <= '0;
            video_de <= 1'b0;
        end else if (pxl_cen) begin
            // Black outside the active area
            video_r  <= active ? video_pkg::extend_color(r_wide, COLORW) : '0;
            video_g  <= active ? video_pkg::extend_color(g_wide, COLORW) : '0;
            video_b  <= active ? video_pkg::extend_color(b_wide, COLORW) : '0;
            video_de <= active;
        end
    end

    // The game colour lands unchanged in the top bits of each channel
    a_top_bits: assert property (@(posedge clk) disable iff (rst)
        pxl_cen && active |=>
        video_r[video_pkg::OUT_W-1 -: COLORW] == $past(game_r)
        && video_g[video_pkg::OUT_W-1 -: COLORW] == $past(game_g)
        && video_b[video_pkg::OUT_W-1 -: COLORW] == $past(game_b));

endmodule

/* ctrl_pkg.sv */
package ctrl_pkg;

    // Bit positions in the 64-bit status word
    localparam int ST_ROTATE   = 2;
    localparam int ST_FLIP     = 5;
    localparam int ST_PAUSE    = 7;
    localparam int ST_FM_OFF   = 8;
    localparam int ST_PSG_OFF  = 9;
    localparam int ST_TEST     = 10;
    localparam int ST_AUTOFIRE = 18;

    // Joystick layout, bits 3:0 are the directions
    localparam int JOY_IN_W  = 16;
    localparam int JOY_OUT_W = 10;
    localparam int JOY_BTN0  = 4;
    localparam int JOY_PAUSE = 10;
    localparam int PLAYERS   = 4;

    typedef enum logic [1:0] {
        RST_HOLD,
        RST_COUNT,
        RST_RUN
    } reset_state_t;

    typedef enum logic [1:0] {
        LED_GAME,
        LED_OSD,
        LED_BLINK
    } led_mode_t;

endpackage

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --top-module tb_board -f board_top.f -o tb_board

./obj_dir/tb_board > sim.log 2>&1 || true
cat sim.log

if grep -qx "all tests passed" sim.log; then
    exit 0
fi
exit 1

/* tb_board.sv */
module tb_board;

    localparam int COLORW       = 4;
    localparam int BUTTONS      = 2;
    localparam int RESET_HOLD   = 16;
    localparam int BLINK_FRAMES = 4;
    localparam int TOTAL_CYCLES = 800;

    logic                          clk;
    logic                          reset;
    logic                          pll_locked;
    logic                          downloading;
    logic                          rst;
    logic                          game_rst;
    logic                          vs;
    logic [ctrl_pkg::JOY_IN_W-1:0]  board_joystick1;
    logic [ctrl_pkg::JOY_IN_W-1:0]  board_joystick2;
    logic [ctrl_pkg::JOY_IN_W-1:0]  board_joystick3;
    logic [ctrl_pkg::JOY_IN_W-1:0]  board_joystick4;
    logic [3:0]                    board_coin;
    logic [3:0]                    board_start;
    logic [ctrl_pkg::JOY_OUT_W-1:0] game_joystick1;
    logic [ctrl_pkg::JOY_OUT_W-1:0] game_joystick2;
    logic [ctrl_pkg::JOY_OUT_W-1:0] game_joystick3;
    logic [ctrl_pkg::JOY_OUT_W-1:0] game_joystick4;
    logic [3:0]                    game_coin;
    logic [3:0]                    game_start;
    logic [63:0]                   status;
    logic                          dip_pause;
    logic                          dip_flip;
    logic                          dip_test;
    logic                          enable_fm;
    logic                          enable_psg;
    logic [1:0]                    rotate;
    logic                          osd_shown;
    logic [1:0]                    game_led;
    logic                          led;
    logic                          pxl_cen;
    logic                          lhbl;
    logic                          lvbl;
    logic [COLORW-1:0]             game_r;
    logic [COLORW-1:0]             game_g;
    logic [COLORW-1:0]             game_b;
    logic [7:0]                    video_r;
    logic [7:0]                    video_g;
    logic [7:0]                    video_b;
    logic                          video_de;

    int          errors = 0;
    logic [31:0] lfsr = 32'h59757e0f;
    logic        armed = 1'b0;
    int          arm_cnt = 0;

    // Reference state for the reset, pause, autofire and LED rules
    int          clr_cnt = 0;
    int          grst_cnt = RESET_HOLD;
    logic        combo_q = 1'b0;
    logic        soft_pulse = 1'b0;
    logic        pause_q = 1'b0;
    logic        pause_m = 1'b0;
    logic        vs_q = 1'b0;
    logic        frame_m = 1'b0;
    logic        af_m = 1'b0;
    logic        lvbl_q = 1'b0;
    int          blink_cnt = 0;
    logic        blink_m = 1'b0;
    logic        rst_exp;
    logic        grst_exp;
    logic        fire_drop;

    board_top i_dut (.*);

    always #4 clk = ~clk;

    assign rst_exp   = reset || !pll_locked || (clr_cnt < RESET_HOLD);
    assign grst_exp  = rst_exp || downloading || soft_pulse || (grst_cnt != 0);
    assign fire_drop = af_m && frame_m;

    always @(posedge clk) begin
        if (arm_cnt < 3) begin
            arm_cnt <= arm_cnt + 1;
        end else begin
            armed <= 1'b1;
        end
        clr_cnt <= (reset || !pll_locked) ? 0 : ((clr_cnt < RESET_HOLD) ? clr_cnt + 1 : clr_cnt);
        if (rst_exp || downloading) begin
            grst_cnt <= RESET_HOLD;
        end else if (soft_pulse) begin
            grst_cnt <= RESET_HOLD - 1;
        end else if (grst_cnt != 0) begin
            grst_cnt <= grst_cnt - 1;
        end
        combo_q    <= rst_exp ? 1'b0 : (board_start[0] && board_coin[0]);
        soft_pulse <= !rst_exp && board_start[0] && board_coin[0] && !combo_q;
        pause_q    <= rst_exp ? 1'b0 : board_joystick1[ctrl_pkg::JOY_PAUSE];
        if (grst_exp) begin
            pause_m <= 1'b0;
        end else if (board_joystick1[ctrl_pkg::JOY_PAUSE] && !pause_q) begin
            pause_m <= !pause_m;
        end
        vs_q <= rst_exp ? 1'b0 : vs;
        if (rst_exp) begin
            frame_m <= 1'b0;
        end else if (vs && !vs_q) begin
            frame_m <= !frame_m;
        end
        af_m   <= rst_exp ? 1'b0 : status[ctrl_pkg::ST_AUTOFIRE];
        lvbl_q <= lvbl;
        if (rst_exp || !downloading) begin
            blink_cnt <= 0;
            blink_m   <= 1'b0;
        end else if (lvbl_q && !lvbl) begin
            if (blink_cnt == BLINK_FRAMES - 1) begin
                blink_cnt <= 0;
                blink_m   <= !blink_m;
            end else begin
                blink_cnt <= blink_cnt + 1;
            end
        end
    end

    // Game side is active low and never sees buttons above BUTTONS
    function automatic logic [9:0] joy_expect(input logic [15:0] j, input logic drop);
        logic [9:0] pressed;
        pressed = j[9:0] & 10'((1 << (4 + BUTTONS)) - 1);
        if (drop) begin
            pressed[ctrl_pkg::JOY_BTN0] = 1'b0;
        end
        return ~pressed;
    endfunction

    function automatic logic [7:0] widen(input logic [COLORW-1:0] c);
        logic [7:0] r;
        for (int i = 0; i < 8; i++) begin
            r[7-i] = c[COLORW - 1 - (i % COLORW)];
        end
        return r;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic count_error(input string msg);
        errors = errors + 1;
        $display("ERR %0t: %s", $time, msg);
    endtask

    a_rst: assert property (@(posedge clk) armed |-> rst == rst_exp)
        else count_error("rst mismatch");
    a_grst: assert property (@(posedge clk) armed |-> game_rst == grst_exp)
        else count_error("game_rst mismatch");
    a_in_reset: assert property (@(posedge clk) armed && $past(rst_exp) |->
        game_joystick1 == 10'h3ff && game_coin == 4'hf && led == 1'b0 && video_de == 1'b0)
        else count_error("outputs not idle in reset");
    a_joy1: assert property (@(posedge clk) armed && !$past(rst_exp) |->
        game_joystick1 == joy_expect($past(board_joystick1), $past(fire_drop)))
        else count_error("game_joystick1 mismatch");
    a_joy2: assert property (@(posedge clk) armed && !$past(rst_exp) |->
        game_joystick2 == joy_expect($past(board_joystick2), $past(fire_drop)))
        else count_error("game_joystick2 mismatch");
    a_joy3: assert property (@(posedge clk) armed && !$past(rst_exp) |->
        game_joystick3 == joy_expect($past(board_joystick3), $past(fire_drop)))
        else count_error("game_joystick3 mismatch");
    a_joy4: assert property (@(posedge clk) armed && !$past(rst_exp) |->
        game_joystick4 == joy_expect($past(board_joystick4), $past(fire_drop)))
        else count_error("game_joystick4 mismatch");
    a_coin: assert property (@(posedge clk) armed && !$past(rst_exp) |->
        game_coin == ~$past(board_coin) && game_start == ~$past(board_start))
        else count_error("coin or start mismatch");
    a_pause: assert property (@(posedge clk) armed && !$past(rst_exp) |->
        dip_pause == ($past(status[ctrl_pkg::ST_PAUSE]) || $past(pause_m)))
        else count_error("dip_pause mismatch");
    a_status: assert property (@(posedge clk) armed && !$past(rst_exp) |->
        dip_flip == $past(status[ctrl_pkg::ST_FLIP]) && dip_test == $past(status[ctrl_pkg::ST_TEST])
        && enable_fm == !$past(status[ctrl_pkg::ST_FM_OFF])
        && enable_psg == !$past(status[ctrl_pkg::ST_PSG_OFF])
        && rotate == $past(status[ctrl_pkg::ST_ROTATE +: 2]))
        else count_error("status decode mismatch");
    a_video: assert property (@(posedge clk) armed && !$past(rst_exp) && $past(pxl_cen) |->
        video_de == ($past(lhbl) && $past(lvbl))
        && video_r == (($past(lhbl) && $past(lvbl)) ? widen($past(game_r)) : 8'h00)
        && video_g == (($past(lhbl) && $past(lvbl)) ? widen($past(game_g)) : 8'h00)
        && video_b == (($past(lhbl) && $past(lvbl)) ? widen($past(game_b)) : 8'h00))
        else count_error("video output mismatch");
    a_video_hold: assert property (@(posedge clk) armed && !$past(rst_exp) && !$past(pxl_cen) |->
        $stable(video_r) && $stable(video_g) && $stable(video_b) && $stable(video_de))
        else count_error("video changed without pxl_cen");
    a_led: assert property (@(posedge clk) armed && !$past(rst_exp) |->
        led == ($past(downloading) ? $past(blink_m)
                : ($past(osd_shown) ? 1'b1 : $past(game_led[0]))))
        else count_error("led mismatch");

    task automatic take(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v[i] = lfsr[0];
        end
    endtask

    task automatic drive_random();
        logic [63:0] v;
        @(posedge clk);
        take(64, v);
        board_joystick1 <= v[15:0];
        board_joystick2 <= v[31:16];
        board_joystick3 <= v[47:32];
        board_joystick4 <= v[63:48];
        take(24, v);
        board_coin  <= v[3:0];
        board_start <= v[7:4];
        game_r      <= v[11:8];
        game_g      <= v[15:12];
        game_b      <= v[19:16];
        pxl_cen     <= v[20];
        lhbl        <= v[21] | v[22];
        lvbl        <= v[23];
        take(4, v);
        vs        <= v[0];
        osd_shown <= v[1];
        game_led  <= v[3:2];
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic clear_players();
        @(posedge clk);
        board_joystick1 <= '0;
        board_joystick2 <= '0;
        board_joystick3 <= '0;
        board_joystick4 <= '0;
        board_coin      <= '0;
        board_start     <= '0;
        osd_shown       <= 1'b0;
        vs              <= 1'b0;
    endtask

    task automatic press_pause();
        @(posedge clk);
        board_joystick1[ctrl_pkg::JOY_PAUSE] <= 1'b1;
        @(posedge clk);
        board_joystick1[ctrl_pkg::JOY_PAUSE] <= 1'b0;
        idle(3);
    endtask

    initial begin
        #(8 * (TOTAL_CYCLES + 100));
        $display("Timeout: simulation did not finish within %0d cycles", TOTAL_CYCLES + 100);
        $display("tests failed");
        $finish;
    end

    initial begin
        logic [63:0] v;
        clk = 1'b0;
        reset = 1'b1;
        pll_locked = 1'b0;
        downloading = 1'b0;
        vs = 1'b0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        board_joystick3 = '0;
        board_joystick4 = '0;
        board_coin = '0;
        board_start = '0;
        status = '0;
        osd_shown = 1'b0;
        game_led = '0;
        pxl_cen = 1'b0;
        lhbl = 1'b0;
        lvbl = 1'b0;
        game_r = '0;
        game_g = '0;
        game_b = '0;
        idle(5);
        reset <= 1'b0;
        @(posedge clk);
        pll_locked <= 1'b1;
        idle(30);

        // Random players, colours and LED input
        repeat (300) drive_random();
        clear_players();
        idle(20);

        // Pause toggle, then the OSD pause bit on top
        repeat (6) press_pause();
        @(posedge clk);
        status[ctrl_pkg::ST_PAUSE] <= 1'b1;
        repeat (4) press_pause();
        @(posedge clk);
        status <= '0;

        // Autofire on a held button 0 across frames
        @(posedge clk);
        status[ctrl_pkg::ST_AUTOFIRE] <= 1'b1;
        board_joystick1 <= 16'h0010;
        board_joystick3 <= 16'h0011;
        repeat (10) begin
            @(posedge clk);
            vs <= 1'b1;
            idle(1);
            @(posedge clk);
            vs <= 1'b0;
            idle(5);
        end
        repeat (40) begin
            @(posedge clk);
            take(64, v);
            status <= v;
        end
        @(posedge clk);
        status <= '0;
        clear_players();

        // Download blink, then the OSD
        @(posedge clk);
        downloading <= 1'b1;
        repeat (12) begin
            @(posedge clk);
            lvbl <= 1'b1;
            idle(3);
            @(posedge clk);
            lvbl <= 1'b0;
            idle(3);
        end
        @(posedge clk);
        downloading <= 1'b0;
        idle(30);
        @(posedge clk);
        osd_shown <= 1'b1;
        idle(10);
        @(posedge clk);
        osd_shown <= 1'b0;

        // Start 0 with coin 0 asks for a game reset
        @(posedge clk);
        board_coin  <= 4'h1;
        board_start <= 4'h1;
        idle(5);
        @(posedge clk);
        board_coin  <= 4'h0;
        board_start <= 4'h0;
        idle(30);

        $display("Run complete with %0d assertion errors", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* video_pkg.sv */
package video_pkg;

    localparam int OUT_W = 8;

    // Value sits in the low w bits of c, its top bits repeat into the tail
    function automatic logic [OUT_W-1:0] extend_color(input logic [OUT_W-1:0] c, input int w);
        logic [OUT_W-1:0] res;
        int               src;
        res = '0;
        src = w - 1;
        for (int i = OUT_W - 1; i >= 0; i--) begin
            res[i] = c[src];
            src    = (src == 0) ? w - 1 : src - 1;
        end
        return res;
    endfunction

endpackage
